//--- rtl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// csr word addresses on the slave port
`define CSR_CRMD 2'd0
`define CSR_DMW0 2'd1
`define CSR_DMW1 2'd2

// crmd fields
`define CRMD_PLV  1:0
`define CRMD_DA   3
`define CRMD_DATF 6:5

// direct mapped window fields
`define DMW_PLV0 0
`define DMW_PLV3 3
`define DMW_MAT  5:4
`define DMW_PSEG 27:25
`define DMW_VSEG 31:29

// DA set, PLV 0, DATF 0
`define CRMD_RESET 32'h0000_0008
`define DMW_RESET  32'h0000_0000

// first fetch address out of reset
`define RESET_PC 32'h1c00_0000

`endif

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  // virtual fetch address
  typedef logic [31:0] vaddr_t;

  // physical address on the imem bus
  typedef logic [31:0] paddr_t;

  // instruction word and bus data
  typedef logic [31:0] word_t;

  // raw csr contents
  typedef logic [31:0] csr_val_t;

  // privilege level, 0 most privileged
  typedef logic [1:0] plv_t;

  // memory access type, 1 means cached
  typedef logic [1:0] mat_t;

  // top three address bits, VSEG and PSEG
  typedef logic [2:0] seg_t;

  // imem read master states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    HOLD
  } bus_state_t;

endpackage

//--- rtl/fetch_csr_regs.sv
`include "fetch_macros.svh"

module fetch_csr_regs (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                csr_cyc_i,
  input  logic                csr_stb_i,
  input  logic                csr_we_i,
  input  logic [1:0]          csr_adr_i,
  input  fetch_pkg::word_t    csr_dat_i,
  output fetch_pkg::word_t    csr_dat_o,
  output logic                csr_ack_o,
  output fetch_pkg::csr_val_t crmd_o,
  output fetch_pkg::csr_val_t dmw0_o,
  output fetch_pkg::csr_val_t dmw1_o,
  output logic                flush_o
);

  import fetch_pkg::*;

  logic  req;
  logic  wr_req;
  word_t rd_data;

  // new request only while no ack is out, so stb held high cannot ack twice
  assign req    = csr_cyc_i & csr_stb_i & ~csr_ack_o;
  assign wr_req = req & csr_we_i;

  always_comb begin
    case (csr_adr_i)
      `CSR_CRMD: rd_data = crmd_o;
      `CSR_DMW0: rd_data = dmw0_o;
      `CSR_DMW1: rd_data = dmw1_o;
      default:   rd_data = '0;
    endcase
  end

  // ack and flush come out together one cycle after the request
  always_ff @(posedge clk) begin
    if (reset_i) begin
      csr_ack_o <= 1'b0;
      flush_o   <= 1'b0;
    end else begin
      csr_ack_o <= req;
      flush_o   <= wr_req;
    end
  end

  // registers take the write on the edge that raises ack
  always_ff @(posedge clk) begin
    if (reset_i) begin
      crmd_o <= `CRMD_RESET;
      dmw0_o <= `DMW_RESET;
      dmw1_o <= `DMW_RESET;
    end else if (wr_req) begin
      case (csr_adr_i)
        `CSR_CRMD: crmd_o <= csr_dat_i;
        `CSR_DMW0: dmw0_o <= csr_dat_i;
        `CSR_DMW1: dmw1_o <= csr_dat_i;
        default: ;
      endcase
    end
  end

  // read data valid alongside ack
  always_ff @(posedge clk) begin
    if (req) begin
      csr_dat_o <= rd_data;
    end
  end

endmodule

//--- rtl/fetch_pc_gen.sv
`include "fetch_macros.svh"

module fetch_pc_gen (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              accept_i,
  input  logic              redirect_valid_i,
  input  fetch_pkg::vaddr_t redirect_pc_i,
  input  logic              flush_i,
  input  fetch_pkg::vaddr_t flush_pc_i,
  output fetch_pkg::vaddr_t pc_o
);

  import fetch_pkg::*;

  vaddr_t pc_next;

  // redirect first, then flush rewind, then sequential step
  always_comb begin
    pc_next = pc_o;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (flush_i) begin
      // retry the dropped fetch under the new csr values
      pc_next = flush_pc_i;
    end else if (accept_i) begin
      pc_next = pc_o + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_o <= `RESET_PC;
    end else begin
      pc_o <= pc_next;
    end
  end

endmodule

//--- rtl/fetch_addr_trans.sv
`include "fetch_macros.svh"

module fetch_addr_trans (
  input  logic                clk,
  input  logic                reset_i,
  input  fetch_pkg::vaddr_t   pc_i,
  output logic                accept_o,
  input  fetch_pkg::csr_val_t crmd_i,
  input  fetch_pkg::csr_val_t dmw0_i,
  input  fetch_pkg::csr_val_t dmw1_i,
  input  logic                flush_i,
  input  logic                redirect_i,
  input  logic                take_i,
  output logic                valid_o,
  output fetch_pkg::vaddr_t   pc_o,
  output fetch_pkg::paddr_t   paddr_o,
  output logic                adef_o,
  output logic                uncached_o
);

  import fetch_pkg::*;

  logic   da_mode;
  mat_t   datf;
  plv_t   plv;
  logic   plv0;
  logic   plv3;
  logic   dmw0_hit;
  logic   dmw1_hit;
  paddr_t paddr_d;
  logic   adef_d;
  logic   uncached_d;
  logic   valid_q;
  vaddr_t pc_q;

  assign da_mode = crmd_i[`CRMD_DA];
  assign datf    = crmd_i[`CRMD_DATF];
  assign plv     = crmd_i[`CRMD_PLV];
  assign plv0    = (plv == 2'd0);
  assign plv3    = (plv == 2'd3);

  // a window needs its plv bit for the current level and a matching vseg
  assign dmw0_hit = ((dmw0_i[`DMW_PLV0] & plv0) | (dmw0_i[`DMW_PLV3] & plv3)) &&
                    (seg_t'(dmw0_i[`DMW_VSEG]) == pc_i[31:29]);
  assign dmw1_hit = ((dmw1_i[`DMW_PLV0] & plv0) | (dmw1_i[`DMW_PLV3] & plv3)) &&
                    (seg_t'(dmw1_i[`DMW_VSEG]) == pc_i[31:29]);

  always_comb begin
    if (da_mode) begin
      paddr_d    = pc_i;
      uncached_d = (datf != 2'd1);
    end else if (dmw0_hit) begin
      // dmw0 wins when both hit
      paddr_d    = {seg_t'(dmw0_i[`DMW_PSEG]), pc_i[28:0]};
      uncached_d = (mat_t'(dmw0_i[`DMW_MAT]) != 2'd1);
    end else begin
      paddr_d    = {seg_t'(dmw1_i[`DMW_PSEG]), pc_i[28:0]};
      uncached_d = (mat_t'(dmw1_i[`DMW_MAT]) != 2'd1);
    end
    adef_d = (|pc_i[1:0]) | (~da_mode & ~dmw0_hit & ~dmw1_hit);
  end

  // load when empty or when the bus master takes the entry
  assign accept_o = (~valid_q | take_i) & ~flush_i & ~redirect_i;

  // a dropped entry is never handed on in the flush or redirect cycle
  assign valid_o = valid_q & ~flush_i & ~redirect_i;

  // empty stage reports the pc waiting to enter, so a flush rewinds to it
  assign pc_o = valid_q ? pc_q : pc_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (flush_i | redirect_i) begin
      valid_q <= 1'b0;
    end else if (accept_o) begin
      valid_q <= 1'b1;
    end else if (take_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_o) begin
      pc_q       <= pc_i;
      paddr_o    <= paddr_d;
      adef_o     <= adef_d;
      uncached_o <= uncached_d;
    end
  end

endmodule

//--- rtl/fetch_bus_master.sv
module fetch_bus_master (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              t_valid_i,
  input  fetch_pkg::vaddr_t t_pc_i,
  input  fetch_pkg::paddr_t t_paddr_i,
  input  logic              t_adef_i,
  input  logic              t_uncached_i,
  output logic              take_o,
  input  logic              redirect_i,
  output logic              im_cyc_o,
  output logic              im_stb_o,
  output fetch_pkg::paddr_t im_adr_o,
  input  fetch_pkg::word_t  im_dat_i,
  input  logic              im_ack_i,
  output logic              inst_valid_o,
  output fetch_pkg::vaddr_t inst_pc_o,
  output fetch_pkg::word_t  inst_o,
  output logic              inst_adef_o,
  output logic              inst_uncached_o,
  input  logic              inst_ready_i
);

  import fetch_pkg::*;

  bus_state_t state_q;
  logic       drop_q;

  // entries are only taken while idle
  assign take_o = (state_q == IDLE) & t_valid_i;

  assign im_cyc_o     = (state_q == REQ);
  assign im_stb_o     = (state_q == REQ);
  assign inst_valid_o = (state_q == HOLD);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      drop_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          drop_q <= 1'b0;
          if (take_o) begin
            // faulting fetch skips the bus
            state_q <= t_adef_i ? HOLD : REQ;
          end
        end
        REQ: begin
          if (redirect_i) begin
            drop_q <= 1'b1;
          end
          // the cycle always runs to ack and a redirected result is thrown away
          if (im_ack_i) begin
            state_q <= (drop_q | redirect_i) ? IDLE : HOLD;
          end
        end
        HOLD: begin
          if (redirect_i | inst_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // entry fields held from one take to the next
  always_ff @(posedge clk) begin
    if (take_o) begin
      inst_pc_o       <= t_pc_i;
      im_adr_o        <= t_paddr_i;
      inst_adef_o     <= t_adef_i;
      inst_uncached_o <= t_uncached_i;
    end
  end

  // instruction word is zero for a fault
  always_ff @(posedge clk) begin
    if (take_o & t_adef_i) begin
      inst_o <= '0;
    end else if ((state_q == REQ) & im_ack_i) begin
      inst_o <= im_dat_i;
    end
  end

endmodule

//--- rtl/fetch_top.sv
module fetch_top (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              csr_cyc_i,
  input  logic              csr_stb_i,
  input  logic              csr_we_i,
  input  logic [1:0]        csr_adr_i,
  input  fetch_pkg::word_t  csr_dat_i,
  output fetch_pkg::word_t  csr_dat_o,
  output logic              csr_ack_o,
  output logic              im_cyc_o,
  output logic              im_stb_o,
  output fetch_pkg::paddr_t im_adr_o,
  input  fetch_pkg::word_t  im_dat_i,
  input  logic              im_ack_i,
  input  logic              redirect_valid_i,
  input  fetch_pkg::vaddr_t redirect_pc_i,
  output logic              inst_valid_o,
  output fetch_pkg::vaddr_t inst_pc_o,
  output fetch_pkg::word_t  inst_o,
  output logic              inst_adef_o,
  output logic              inst_uncached_o,
  input  logic              inst_ready_i
);

  import fetch_pkg::*;

  csr_val_t crmd;
  csr_val_t dmw0;
  csr_val_t dmw1;
  logic     csr_flush;
  vaddr_t   pc;
  logic     pc_accept;
  logic     t_valid;
  vaddr_t   t_pc;
  paddr_t   t_paddr;
  logic     t_adef;
  logic     t_uncached;
  logic     t_take;

  fetch_csr_regs u_csr (
    .clk       (clk),
    .reset_i   (reset_i),
    .csr_cyc_i (csr_cyc_i),
    .csr_stb_i (csr_stb_i),
    .csr_we_i  (csr_we_i),
    .csr_adr_i (csr_adr_i),
    .csr_dat_i (csr_dat_i),
    .csr_dat_o (csr_dat_o),
    .csr_ack_o (csr_ack_o),
    .crmd_o    (crmd),
    .dmw0_o    (dmw0),
    .dmw1_o    (dmw1),
    .flush_o   (csr_flush)
  );

  // a flush rewinds to the pc the translation stage gives up
  fetch_pc_gen u_pc_gen (
    .clk              (clk),
    .reset_i          (reset_i),
    .accept_i         (pc_accept),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .flush_i          (csr_flush),
    .flush_pc_i       (t_pc),
    .pc_o             (pc)
  );

  fetch_addr_trans u_trans (
    .clk        (clk),
    .reset_i    (reset_i),
    .pc_i       (pc),
    .accept_o   (pc_accept),
    .crmd_i     (crmd),
    .dmw0_i     (dmw0),
    .dmw1_i     (dmw1),
    .flush_i    (csr_flush),
    .redirect_i (redirect_valid_i),
    .take_i     (t_take),
    .valid_o    (t_valid),
    .pc_o       (t_pc),
    .paddr_o    (t_paddr),
    .adef_o     (t_adef),
    .uncached_o (t_uncached)
  );

  fetch_bus_master u_bus (
    .clk             (clk),
    .reset_i         (reset_i),
    .t_valid_i       (t_valid),
    .t_pc_i          (t_pc),
    .t_paddr_i       (t_paddr),
    .t_adef_i        (t_adef),
    .t_uncached_i    (t_uncached),
    .take_o          (t_take),
    .redirect_i      (redirect_valid_i),
    .im_cyc_o        (im_cyc_o),
    .im_stb_o        (im_stb_o),
    .im_adr_o        (im_adr_o),
    .im_dat_i        (im_dat_i),
    .im_ack_i        (im_ack_i),
    .inst_valid_o    (inst_valid_o),
    .inst_pc_o       (inst_pc_o),
    .inst_o          (inst_o),
    .inst_adef_o     (inst_adef_o),
    .inst_uncached_o (inst_uncached_o),
    .inst_ready_i    (inst_ready_i)
  );

endmodule

//--- sim/fetch_clk_gen.sv
module fetch_clk_gen (
  output logic clk,
  output logic reset_i
);

  // 20 unit period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for the first 4 rising edges
  initial begin
    reset_i = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset_i = 1'b0;
  end

endmodule

//--- sim/fetch_properties.sv
module fetch_properties (
  input logic        clk,
  input logic        reset_i,
  input logic        im_cyc_o,
  input logic        im_stb_o,
  input logic [31:0] im_adr_o,
  input logic        im_ack_i,
  input logic        inst_valid_o,
  input logic [31:0] inst_pc_o,
  input logic        inst_adef_o,
  input logic        inst_ready_i,
  input logic        redirect_valid_i,
  input logic        csr_ack_o
);

  // an open bus cycle keeps cyc and the address until ack
  assert property (@(posedge clk) disable iff (reset_i)
    (im_cyc_o && im_stb_o && !im_ack_i) |=> (im_cyc_o && $stable(im_adr_o)))
    else $error("imem address changed before ack");

  // output entry is held until the consumer takes it
  assert property (@(posedge clk) disable iff (reset_i)
    (inst_valid_o && !inst_ready_i && !redirect_valid_i) |=>
    (inst_valid_o && $stable(inst_pc_o)))
    else $error("inst_valid_o dropped or inst_pc_o changed without ready");

  assert property (@(posedge clk) disable iff (reset_i)
    csr_ack_o |=> !csr_ack_o)
    else $error("csr_ack_o high two cycles in a row");

  // a fault goes straight to hold, so no bus cycle ran for it
  assert property (@(posedge clk) disable iff (reset_i)
    (inst_valid_o && inst_adef_o) |-> (!im_cyc_o && !$past(im_cyc_o)))
    else $error("bus cycle started for a faulting fetch");

endmodule

bind fetch_top fetch_properties props0 (
  .clk              (clk),
  .reset_i          (reset_i),
  .im_cyc_o         (im_cyc_o),
  .im_stb_o         (im_stb_o),
  .im_adr_o         (im_adr_o),
  .im_ack_i         (im_ack_i),
  .inst_valid_o     (inst_valid_o),
  .inst_pc_o        (inst_pc_o),
  .inst_adef_o      (inst_adef_o),
  .inst_ready_i     (inst_ready_i),
  .redirect_valid_i (redirect_valid_i),
  .csr_ack_o        (csr_ack_o)
);

//--- sim/fetch_tb.sv
`include "fetch_macros.svh"

module fetch_tb;

  import fetch_pkg::*;

  logic clk;
  logic reset_i;
  logic csr_cyc_i;
  logic csr_stb_i;
  logic csr_we_i;
  logic [1:0] csr_adr_i;
  word_t csr_dat_i;
  word_t csr_dat_o;
  logic csr_ack_o;
  logic im_cyc_o;
  logic im_stb_o;
  paddr_t im_adr_o;
  word_t im_dat_i;
  logic im_ack_i;
  logic redirect_valid_i;
  vaddr_t redirect_pc_i;
  logic inst_valid_o;
  vaddr_t inst_pc_o;
  word_t inst_o;
  logic inst_adef_o;
  logic inst_uncached_o;
  logic inst_ready_i;

  // expected csr contents and the values before the latest write
  csr_val_t crmd_s;
  csr_val_t dmw0_s;
  csr_val_t dmw1_s;
  csr_val_t crmd_p;
  csr_val_t dmw0_p;
  csr_val_t dmw1_p;
  bit grace;
  int delivered;
  int cycles;
  int cycle_limit;
  logic [31:0] lfsr;
  bit mem_busy;
  int mem_wait;

  fetch_clk_gen clk_gen0 (.clk(clk), .reset_i(reset_i));

  fetch_top dut0 (.*);

  function automatic bit rand_bit();
    bit b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic bit window_hit(input csr_val_t dmw, input plv_t plv, input vaddr_t va);
    bit priv;
    priv = (plv == 2'd0 && dmw[`DMW_PLV0]) || (plv == 2'd3 && dmw[`DMW_PLV3]);
    return priv && (dmw[`DMW_VSEG] == va[31:29]);
  endfunction

  function automatic void ref_translate(input vaddr_t va, input csr_val_t crmd,
                                        input csr_val_t d0, input csr_val_t d1,
                                        output paddr_t pa, output logic adef,
                                        output logic unc);
    bit h0;
    bit h1;
    h0 = window_hit(d0, crmd[`CRMD_PLV], va);
    h1 = window_hit(d1, crmd[`CRMD_PLV], va);
    pa = va;
    unc = (crmd[`CRMD_DATF] != 2'd1);
    adef = (va[1:0] != 2'b00);
    if (!crmd[`CRMD_DA]) begin
      if (h0) begin
        pa = {d0[`DMW_PSEG], va[28:0]};
        unc = (d0[`DMW_MAT] != 2'd1);
      end else if (h1) begin
        pa = {d1[`DMW_PSEG], va[28:0]};
        unc = (d1[`DMW_MAT] != 2'd1);
      end else begin
        adef = 1'b1;
      end
    end
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // memory model returns the inverted address after 0 to 3 wait cycles
  always begin
    @(posedge clk);
    #1;
    if (im_ack_i) begin
      im_ack_i = 1'b0;
      mem_busy = 1'b0;
    end else if (im_cyc_o && im_stb_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = {rand_bit(), rand_bit()};
      end
      if (mem_wait == 0) begin
        im_ack_i = 1'b1;
        im_dat_i = ~im_adr_o;
      end else begin
        mem_wait = mem_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  task automatic csr_write(input logic [1:0] adr, input word_t data);
    @(posedge clk);
    #1;
    csr_cyc_i = 1'b1;
    csr_stb_i = 1'b1;
    csr_we_i = 1'b1;
    csr_adr_i = adr;
    csr_dat_i = data;
    do @(negedge clk); while (!csr_ack_o);
    @(posedge clk);
    #1;
    csr_cyc_i = 1'b0;
    csr_stb_i = 1'b0;
    csr_we_i = 1'b0;
    crmd_p = crmd_s;
    dmw0_p = dmw0_s;
    dmw1_p = dmw1_s;
    case (adr)
      `CSR_CRMD: crmd_s = data;
      `CSR_DMW0: dmw0_s = data;
      `CSR_DMW1: dmw1_s = data;
      default: ;
    endcase
    grace = 1'b1;
  endtask

  task automatic csr_read(input logic [1:0] adr, input word_t exp);
    @(posedge clk);
    #1;
    csr_cyc_i = 1'b1;
    csr_stb_i = 1'b1;
    csr_adr_i = adr;
    do @(negedge clk); while (!csr_ack_o);
    check("csr_dat_o", csr_dat_o, exp);
    @(posedge clk);
    #1;
    csr_cyc_i = 1'b0;
    csr_stb_i = 1'b0;
  endtask

  task automatic redirect(input vaddr_t pc);
    @(posedge clk);
    #1;
    inst_ready_i = 1'b0;
    redirect_valid_i = 1'b1;
    redirect_pc_i = pc;
    @(posedge clk);
    #1;
    redirect_valid_i = 1'b0;
    grace = 1'b0;
  endtask

  // takes n instructions and expects sequential pcs from start
  task automatic collect(input vaddr_t start, input int n, input bit rnd);
    vaddr_t pc;
    paddr_t pa;
    paddr_t pa_p;
    logic adef;
    logic adef_p;
    logic unc;
    logic unc_p;
    int got;
    pc = start;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      #1;
      inst_ready_i = rnd ? rand_bit() : 1'b1;
      @(negedge clk);
      if (inst_valid_o && inst_ready_i) begin
        ref_translate(pc, crmd_s, dmw0_s, dmw1_s, pa, adef, unc);
        ref_translate(pc, crmd_p, dmw0_p, dmw1_p, pa_p, adef_p, unc_p);
        // the entry already in the bus master may still carry the old mapping
        if (grace && !adef_p && inst_o === ~pa_p && inst_o !== ~pa) begin
          pa = pa_p;
          adef = adef_p;
          unc = unc_p;
        end
        grace = 1'b0;
        check("inst_pc_o", inst_pc_o, pc);
        check("inst_adef_o", inst_adef_o, adef);
        check("inst_o", inst_o, adef ? 32'h0 : ~pa);
        if (!adef) begin
          check("inst_uncached_o", inst_uncached_o, unc);
        end
        pc = pc + 32'd4;
        got = got + 1;
        delivered = delivered + 1;
      end
    end
    @(posedge clk);
    #1;
    inst_ready_i = 1'b0;
  endtask

  task automatic reset_state_da_fetch();
    csr_read(`CSR_CRMD, `CRMD_RESET);
    csr_read(`CSR_DMW0, `DMW_RESET);
    csr_read(`CSR_DMW1, `DMW_RESET);
    csr_read(2'd3, 32'h0);
    collect(`RESET_PC, 8, 1'b0);
  endtask

  task automatic mapped_windows();
    csr_write(`CSR_DMW0, (32'd5 << 29) | (32'd1 << 25) | (32'd1 << 4) | 32'd1);
    csr_write(`CSR_DMW1, (32'd4 << 29) | (32'd3 << 25) | 32'd1);
    csr_write(`CSR_CRMD, 32'h0);
    redirect(32'ha000_0100);
    collect(32'ha000_0100, 4, 1'b0);
    redirect(32'h8000_0200);
    collect(32'h8000_0200, 4, 1'b0);
    // both windows on segment 5 where dmw0 must win
    csr_write(`CSR_DMW1, (32'd5 << 29) | (32'd3 << 25) | 32'd1);
    redirect(32'ha000_0300);
    collect(32'ha000_0300, 3, 1'b0);
  endtask

  task automatic privilege_filtering();
    csr_write(`CSR_CRMD, 32'h3);
    redirect(32'ha000_0400);
    collect(32'ha000_0400, 2, 1'b0);
    csr_write(`CSR_DMW0, dmw0_s | 32'h8);
    redirect(32'ha000_0400);
    collect(32'ha000_0400, 2, 1'b0);
  endtask

  task automatic address_faults();
    redirect(32'ha000_0402);
    collect(32'ha000_0402, 2, 1'b0);
    redirect(32'h2000_0000);
    collect(32'h2000_0000, 2, 1'b0);
    csr_write(`CSR_CRMD, `CRMD_RESET);
    redirect(32'h1c00_0002);
    collect(32'h1c00_0002, 2, 1'b0);
    redirect(32'h2000_0000);
    collect(32'h2000_0000, 2, 1'b0);
  endtask

  task automatic random_backpressure();
    redirect(32'h1c00_1000);
    collect(32'h1c00_1000, 40, 1'b1);
  endtask

  task automatic midstream_remap();
    int base;
    csr_write(`CSR_DMW0, (32'd5 << 29) | (32'd1 << 25) | (32'd1 << 4) | 32'd1);
    csr_write(`CSR_CRMD, 32'h0);
    redirect(32'ha000_2000);
    base = delivered;
    fork
      collect(32'ha000_2000, 20, 1'b1);
      begin
        wait (delivered >= base + 5);
        csr_write(`CSR_DMW0, (32'd5 << 29) | (32'd2 << 25) | (32'd1 << 4) | 32'd1);
      end
    join
  endtask

  initial begin
    lfsr = 32'h3313_d7dd;
    cycles = 0;
    cycle_limit = 20 * 91 + 200;
    delivered = 0;
    grace = 1'b0;
    mem_busy = 1'b0;
    mem_wait = 0;
    crmd_s = `CRMD_RESET;
    dmw0_s = `DMW_RESET;
    dmw1_s = `DMW_RESET;
    crmd_p = crmd_s;
    dmw0_p = dmw0_s;
    dmw1_p = dmw1_s;
    csr_cyc_i = 1'b0;
    csr_stb_i = 1'b0;
    csr_we_i = 1'b0;
    csr_adr_i = 2'd0;
    csr_dat_i = '0;
    im_dat_i = '0;
    im_ack_i = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i = 1'b0;
    wait (reset_i === 1'b0);
    reset_state_da_fetch();
    mapped_windows();
    privilege_filtering();
    address_faults();
    random_backpressure();
    midstream_remap();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_csr_regs.sv
rtl/fetch_pc_gen.sv
rtl/fetch_addr_trans.sv
rtl/fetch_bus_master.sv
rtl/fetch_top.sv
sim/fetch_clk_gen.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

//--- Makefile
# Verilator flow for the fetch front end testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module fetch_tb

obj_dir/fetch_sim: sources.f rtl/*.sv rtl/*.svh sim/*.sv
	verilator --binary --timing --assert -f sources.f --top-module fetch_tb -o fetch_sim

sim: obj_dir/fetch_sim
	./obj_dir/fetch_sim > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
